// File: dv/elevator_cases.txt
# press <car|up|down|open|close> <floor> <start cycle or delay> <hold cycles>
# stop <floor> lists the expected door stops in order
scenario
press car 5 0 1
stop 5
scenario
press car 0 0 1
stop 0
scenario
press car 2 0 1
press car 6 0 1
press down 4 0 1
stop 2
stop 6
stop 4
scenario
press car 1 0 1
press close 1 3 1
stop 1
scenario
press car 3 0 1
press car 3 80 1
stop 3
stop 3
scenario
press car 3 0 6
stop 3
stop 3
scenario
press car 0 0 1
press open 0 0 1
stop 0
scenario

// File: sources.f
src/elevator_pkg.sv
src/call_registers.sv
src/travel_planner.sv
src/car_controller.sv
src/elevator_top.sv
dv/elevator_checker.sv
dv/elevator_tb.sv

// File: Bender.yml
package:
  name: elevator

sources:
  - src/elevator_pkg.sv
  - src/call_registers.sv
  - src/travel_planner.sv
  - src/car_controller.sv
  - src/elevator_top.sv
  - target: test
    files:
      - dv/elevator_checker.sv
      - dv/elevator_tb.sv

// File: dv/elevator_tb.sv
// reads dv/elevator_cases.txt from the project root; each scenario starts with the car parked and idle
`timescale 1ns/100ps
`default_nettype none

module elevator_tb;

	import elevator_pkg::*;

	logic clk;
	logic reset;
	calls_t btn;
	logic open_btn;
	logic close_btn;
	engine_e engine;
	door_e door;
	floor_t level_display;

	int p_scen[$];	// one entry per press
	int p_kind[$];	// 0 car, 1 up, 2 down, 3 open, 4 close
	int p_floor[$];
	int p_start[$];	// cycle, or delay after the door phase for open and close
	int p_hold[$];
	int e_scen[$];
	int e_floor[$];
	int num_scen;
	int limit_cycles;
	int setup_errors;
	int seed;

	elevator_top dut (
		.clk(clk),
		.reset(reset),
		.btn(btn),
		.open_btn(open_btn),
		.close_btn(close_btn),
		.engine(engine),
		.door(door),
		.level_display(level_display)
	);

	elevator_checker chk (
		.clk(clk),
		.reset(reset),
		.engine(engine),
		.door(door),
		.level_display(level_display),
		.open_btn(open_btn),
		.close_btn(close_btn)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic read_cases(input int fd);
		reg [8*16-1:0] tok;
		reg [8*128-1:0] line;
		int kind;
		int f;
		int st;
		int hd;
		int n;
		n = $fscanf(fd, "%s", tok);
		while (n == 1) begin
			if (tok == "#") begin
				n = $fgets(line, fd);	// skip the rest of a comment line
			end else if (tok == "scenario") begin
				num_scen++;
			end else if (tok == "stop") begin
				n = $fscanf(fd, "%d", f);
				e_scen.push_back(num_scen - 1);
				e_floor.push_back(f);
			end else if (tok == "press") begin
				n = $fscanf(fd, "%s %d %d %d", tok, f, st, hd);
				kind = (tok == "car") ? 0 : (tok == "up") ? 1 : (tok == "down") ? 2
					: (tok == "open") ? 3 : 4;
				p_scen.push_back(num_scen - 1);
				p_kind.push_back(kind);
				p_floor.push_back(f);
				p_start.push_back(st);
				p_hold.push_back(hd);
				limit_cycles += 8 * (segment_cycles + 1) + dwell_cycles + 2 * door_move_cycles;
				limit_cycles += st + hd;
			end else begin
				$display("unknown token in case file: %0s", tok);
				setup_errors++;
			end
			n = $fscanf(fd, "%s", tok);
		end
	endtask

	task automatic drive_presses(input int s);
		calls_t b;
		int last;
		last = 0;
		foreach (p_scen[i]) begin
			if (p_scen[i] == s && p_kind[i] < 3 && p_start[i] + p_hold[i] > last) begin
				last = p_start[i] + p_hold[i];
			end
		end
		for (int cyc = 0; cyc <= last; cyc++) begin
			@(posedge clk);
			b = '0;
			foreach (p_scen[i]) begin
				if (p_scen[i] == s && cyc >= p_start[i] && cyc < p_start[i] + p_hold[i]) begin
					case (p_kind[i])
						0: b.car[p_floor[i]] = 1'b1;
						1: b.hall_up[p_floor[i]] = 1'b1;
						2: b.hall_down[p_floor[i]] = 1'b1;
						default: ;
					endcase
				end
			end
			btn <= b;
		end
	endtask

	// open and close are pressed relative to the door phase at a floor
	task automatic drive_door_buttons(input int s);
		door_e prev;
		door_e want_from;
		door_e want_to;
		foreach (p_scen[i]) begin
			if (p_scen[i] == s && p_kind[i] >= 3) begin
				want_from = (p_kind[i] == 3) ? door_idle : door_open;
				want_to = (p_kind[i] == 3) ? door_close : door_idle;
				prev = door;
				@(posedge clk);
				while (!(door == want_to && prev == want_from && level_display == p_floor[i])) begin
					prev = door;
					@(posedge clk);
				end
				repeat (p_start[i]) @(posedge clk);
				if (p_kind[i] == 3) open_btn <= 1'b1;
				else close_btn <= 1'b1;
				repeat (p_hold[i]) @(posedge clk);
				open_btn <= 1'b0;
				close_btn <= 1'b0;
			end
		end
	endtask

	task automatic wait_settled;
		int idle;
		idle = 0;
		while (idle < 20) begin
			@(posedge clk);
			if (engine == eng_idle && door == door_idle && dut.u_calls.calls == '0) idle++;
			else idle = 0;
		end
	endtask

	task automatic random_burst;
		calls_t b;
		int r;
		for (int cyc = 0; cyc < 150; cyc++) begin
			@(posedge clk);
			r = $random(seed);
			b = '0;
			if (r[4:0] == 5'd0) begin
				case (r[6:5])
					2'd0: b.car[r[10:8]] = 1'b1;
					2'd1: b.hall_up[r[10:8]] = 1'b1;
					default: b.hall_down[r[10:8]] = 1'b1;
				endcase
			end
			btn <= b;
		end
		@(posedge clk);
		btn <= '0;
	endtask

	task automatic run_all;
		repeat (2) @(posedge clk);
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		for (int s = 0; s < num_scen; s++) begin
			chk.clear_stops();
			foreach (e_scen[i]) if (e_scen[i] == s) chk.expect_stop(e_floor[i]);
			fork
				drive_presses(s);
				drive_door_buttons(s);
			join
			wait_settled();
			chk.compare_stops(s);
		end
		chk.clear_stops();	// rules only for the random burst
		random_burst();
		wait_settled();
	endtask

	initial begin
		int fd;
		btn = '0;
		open_btn = 1'b0;
		close_btn = 1'b0;
		reset = 1'b0;
		num_scen = 0;
		limit_cycles = 0;
		setup_errors = 0;
		seed = 32'h1f4b_352a;
		fd = $fopen("dv/elevator_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file dv/elevator_cases.txt");
			$display("errors: setup 1, rule %0d, stop order %0d", chk.rule_errors,
				chk.stop_errors);
			$display("TESTS FAILED");
			$finish;
		end else begin
			read_cases(fd);
			$fclose(fd);
			limit_cycles += num_scen * 60 + 150 + 500;	// idle waits, burst and margin
			run_all();
			$display("errors: setup %0d, rule %0d, stop order %0d", setup_errors,
				chk.rule_errors, chk.stop_errors);
			if (setup_errors == 0 && chk.rule_errors == 0 && chk.stop_errors == 0) begin
				$display("TESTS PASSED");
			end else begin
				$display("TESTS FAILED");
			end
			$finish;
		end
	end

	// the case file is read at time 0, so the limit is complete by the first edge
	initial begin
		@(posedge clk);
		repeat (limit_cycles + 10) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", limit_cycles);
		$display("errors: setup %0d, rule %0d, stop order %0d", setup_errors + 1,
			chk.rule_errors, chk.stop_errors);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/elevator_checker.sv
// samples on the rising edge; a reopen during closing is not counted as a new stop
`timescale 1ns/100ps
`default_nettype none

module elevator_checker (
	input wire logic clk,
	input wire logic reset,
	input wire elevator_pkg::engine_e engine,
	input wire elevator_pkg::door_e door,
	input wire elevator_pkg::floor_t level_display,
	input wire logic open_btn,
	input wire logic close_btn
);

	import elevator_pkg::*;

	int rule_errors = 0;
	int stop_errors = 0;
	int stops[$];	// floors where a door sequence began
	int expected[$];
	engine_e prev_engine;
	door_e prev_door;
	floor_t prev_level;
	int eng_cnt;
	int door_cnt;
	logic in_dwell;
	int close_at;	// dwell sample where close_btn was first seen
	logic open_seen;
	logic first_sample;

	task automatic report_rule(input string msg);
		$display("Fail %0t: %0s", $time, msg);
		rule_errors++;
	endtask

	task automatic clear_stops;
		stops.delete();
		expected.delete();
	endtask

	task automatic expect_stop(input int f);
		expected.push_back(f);
	endtask

	task automatic compare_stops(input int s);
		string got;
		string want;
		logic bad;
		got = "";
		want = "";
		bad = stops.size() != expected.size();
		foreach (stops[i]) got = $sformatf("%0s %0d", got, stops[i]);
		foreach (expected[i]) begin
			want = $sformatf("%0s %0d", want, expected[i]);
			if (i < stops.size() && stops[i] != expected[i]) bad = 1'b1;
		end
		if (bad) begin
			$display("Fail %0t: scenario %0d stops [%0s ] expected [%0s ]", $time, s, got, want);
			stop_errors++;
		end
	endtask

	always @(posedge clk or negedge reset) begin
		if (!reset) begin
			prev_engine = eng_idle;
			prev_door = door_idle;
			prev_level = '0;
			eng_cnt = 0;
			door_cnt = 0;
			in_dwell = 1'b0;
			close_at = 0;
			open_seen = 1'b0;
			first_sample = 1'b1;
		end else begin
			if (first_sample && (engine != eng_idle || door != door_idle || level_display != '0))
				report_rule("outputs not idle at floor 0 after reset");
			first_sample = 1'b0;
			if (engine != eng_idle && door != door_idle) report_rule("engine and door both active");
			if (engine != eng_idle) eng_cnt++;
			if (engine == eng_idle && prev_engine != eng_idle) begin
				if (eng_cnt != segment_cycles) report_rule($sformatf("segment took %0d cycles", eng_cnt));
				if (level_display != (prev_engine == eng_up ? prev_level + 1 : prev_level - 1))
					report_rule($sformatf("display went %0d to %0d", prev_level, level_display));
				eng_cnt = 0;
			end else if (level_display != prev_level) begin
				report_rule("display changed outside a segment end");
			end
			if (door == prev_door) begin
				door_cnt++;
			end else begin
				case (prev_door)
					door_open: if (door_cnt != door_move_cycles) report_rule("door open phase length");
					door_idle: begin
						if (in_dwell) begin
							if (door_cnt != (close_at != 0 ? close_at : dwell_cycles))
								report_rule($sformatf("dwell took %0d cycles", door_cnt));
						end else if (door == door_open) begin
							stops.push_back(level_display);
						end
					end
					door_close: begin
						if (door == door_open) begin
							if (!open_seen) report_rule("door reopened without open_btn");
						end else if (open_seen) begin
							report_rule("door did not reopen on open_btn");
						end else if (door_cnt != door_move_cycles) begin
							report_rule("door close phase length");
						end
					end
					default: report_rule("unknown door command");
				endcase
				in_dwell = prev_door == door_open;	// open is always followed by dwell
				door_cnt = 1;
				close_at = 0;
				open_seen = 1'b0;
			end
			if (door == door_idle && in_dwell && close_btn && close_at == 0) close_at = door_cnt;
			if (door == door_close && open_btn) open_seen = 1'b1;
			prev_engine = engine;
			prev_door = door;
			prev_level = level_display;
		end
	end

endmodule

`default_nettype wire

// File: src/elevator_top.sv
// single-car top; buttons are plain levels and the car starts parked at floor 0, door closed
`timescale 1ns/100ps
`default_nettype none

module elevator_top (
	input wire logic clk,
	input wire logic reset,
	input wire elevator_pkg::calls_t btn,
	input wire logic open_btn,
	input wire logic close_btn,
	output elevator_pkg::engine_e engine,
	output elevator_pkg::door_e door,
	output elevator_pkg::floor_t level_display
);

	import elevator_pkg::*;

	calls_t calls;	// latched requests
	plan_t plan;
	serve_t serve;
	floor_t floor;
	logic dir_up;

	call_registers u_calls (
		.clk(clk),
		.reset(reset),
		.btn(btn),
		.serve(serve),
		.calls(calls)
	);

	travel_planner u_planner (
		.calls(calls),
		.floor(floor),
		.dir_up(dir_up),
		.plan(plan)
	);

	car_controller u_car (
		.clk(clk),
		.reset(reset),
		.open_btn(open_btn),
		.close_btn(close_btn),
		.plan(plan),
		.floor(floor),
		.dir_up(dir_up),
		.serve(serve),
		.engine(engine),
		.door(door),
		.level_display(level_display)
	);

endmodule

`default_nettype wire

// File: src/car_controller.sv
// one floor per segment; open_btn only reopens an idle car or a closing door, close_btn cuts dwell
`timescale 1ns/100ps
`default_nettype none

module car_controller (
	input wire logic clk,
	input wire logic reset,
	input wire logic open_btn,
	input wire logic close_btn,
	input wire elevator_pkg::plan_t plan,
	output elevator_pkg::floor_t floor,
	output logic dir_up,
	output elevator_pkg::serve_t serve,
	output elevator_pkg::engine_e engine,
	output elevator_pkg::door_e door,
	output elevator_pkg::floor_t level_display
);

	import elevator_pkg::*;

	typedef enum logic [2:0] {
		st_parked,
		st_moving,
		st_opening,
		st_dwell,
		st_closing
	} state_e;

	state_e state;
	logic [3:0] cnt;	// shared by segment, door and dwell timing
	logic seg_done;
	logic door_done;
	logic dwell_done;

	assign seg_done = cnt == 4'(segment_cycles - 1);
	assign door_done = cnt == 4'(door_move_cycles - 1);
	assign dwell_done = cnt == 4'(dwell_cycles - 1);

	assign level_display = floor;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= st_parked;
			cnt <= '0;
			floor <= '0;
			dir_up <= 1'b1;
			engine <= eng_idle;
			door <= door_idle;
			serve <= '0;
		end else begin
			serve.valid <= 1'b0;	// strobe lasts one cycle
			case (state)
				st_parked: begin	// also the decision cycle after each segment
					cnt <= '0;
					if (plan.stop_here) begin
						state <= st_opening;
						door <= door_open;
						dir_up <= plan.go_up;
						serve.valid <= 1'b1;
						serve.floor <= floor;
						serve.up <= plan.serve_up;
					end else if (open_btn && !plan.any_call) begin
						state <= st_opening;	// reopen, nothing to serve
						door <= door_open;
					end else if (plan.any_call) begin
						state <= st_moving;
						dir_up <= plan.go_up;
						engine <= plan.go_up ? eng_up : eng_down;
					end
				end
				st_moving: begin
					if (seg_done) begin
						state <= st_parked;
						cnt <= '0;
						engine <= eng_idle;
						floor <= dir_up ? floor + 3'd1 : floor - 3'd1;
					end else begin
						cnt <= cnt + 4'd1;
					end
				end
				st_opening: begin
					if (door_done) begin
						state <= st_dwell;
						cnt <= '0;
						door <= door_idle;
					end else begin
						cnt <= cnt + 4'd1;
					end
				end
				st_dwell: begin
					if (dwell_done || close_btn) begin
						state <= st_closing;
						cnt <= '0;
						door <= door_close;
					end else begin
						cnt <= cnt + 4'd1;
					end
				end
				st_closing: begin
					if (open_btn) begin
						state <= st_opening;	// back to a full open phase
						cnt <= '0;
						door <= door_open;
					end else if (door_done) begin
						state <= st_parked;
						cnt <= '0;
						door <= door_idle;
					end else begin
						cnt <= cnt + 4'd1;
					end
				end
				default: begin
					state <= st_parked;
					cnt <= '0;
					engine <= eng_idle;
					door <= door_idle;
				end
			endcase
		end
	end

	a_engine_door_excl: assert property (
		@(posedge clk) disable iff (!reset)
		!(engine != eng_idle && door != door_idle)
	) else $error("engine and door active together");

	// any floor change is one step, no wrap, in the direction the engine drove
	a_floor_step: assert property (
		@(posedge clk) disable iff (!reset)
		floor != $past(floor) |-> ($past(engine) == eng_up
			? {1'b0, floor} == {1'b0, $past(floor)} + 4'd1
			: $past(engine) == eng_down && {1'b0, floor} + 4'd1 == {1'b0, $past(floor)})
	) else $error("floor did not step by one in the engine direction");

endmodule

`default_nettype wire

// File: src/travel_planner.sv
// purely combinational; assumes floor stays in 0..num_floors-1 and calls come from call_registers
`timescale 1ns/100ps
`default_nettype none

module travel_planner (
	input wire elevator_pkg::calls_t calls,
	input wire elevator_pkg::floor_t floor,
	input wire logic dir_up,
	output elevator_pkg::plan_t plan
);

	import elevator_pkg::*;

	floor_mask_t all_calls;
	floor_mask_t here;	// one-hot of the current floor
	floor_mask_t at_or_below;
	floor_mask_t above;
	floor_mask_t below;
	floor_mask_t ahead;
	logic any_above;
	logic any_below;
	logic go_up;
	logic no_ahead;
	logic car_here;
	logic up_here;
	logic down_here;
	logic take_fwd;	// hall call here in the travel direction

	assign all_calls = calls.car | calls.hall_up | calls.hall_down;

	assign here = floor_mask_t'(1) << floor;
	assign at_or_below = (here << 1) - floor_mask_t'(1);	// wraps to all ones at the top
	assign above = all_calls & ~at_or_below;
	assign below = all_calls & (here - floor_mask_t'(1));

	assign any_above = |above;
	assign any_below = |below;

	// keep going while anything lies ahead, otherwise turn round
	always_comb begin
		if (dir_up) begin
			go_up = any_above || !any_below;
		end else begin
			go_up = any_above && !any_below;
		end
	end

	assign ahead = go_up ? above : below;
	assign no_ahead = ~|ahead;

	assign car_here = |(calls.car & here);
	assign up_here = |(calls.hall_up & here);
	assign down_here = |(calls.hall_down & here);
	assign take_fwd = go_up ? up_here : down_here;

	always_comb begin
		plan.go_up = go_up;
		plan.any_call = |all_calls;
		// last call ahead picks up a hall call either way
		plan.stop_here = car_here || take_fwd || (no_ahead && (up_here || down_here));
		if (take_fwd || !no_ahead) begin
			plan.serve_up = go_up;
		end else begin
			plan.serve_up = !go_up;	// turning round here
		end
	end

endmodule

`default_nettype wire

// File: src/call_registers.sv
// button levels latch every cycle they are high; a button held in the serve cycle keeps its call
`timescale 1ns/100ps
`default_nettype none

module call_registers (
	input wire logic clk,
	input wire logic reset,
	input wire elevator_pkg::calls_t btn,
	input wire elevator_pkg::serve_t serve,
	output elevator_pkg::calls_t calls
);

	import elevator_pkg::*;

	floor_mask_t serve_mask;	// one-hot of the served floor
	floor_mask_t clr_up;
	floor_mask_t clr_down;
	calls_t next_calls;

	assign serve_mask = serve.valid ? (floor_mask_t'(1) << serve.floor) : '0;
	assign clr_up = serve.up ? serve_mask : '0;
	assign clr_down = serve.up ? '0 : serve_mask;

	// no up call at the top floor, no down call at the bottom
	always_comb begin
		next_calls.car = (calls.car & ~serve_mask) | btn.car;
		next_calls.hall_up = ((calls.hall_up & ~clr_up) | btn.hall_up)
			& ~(floor_mask_t'(1) << (num_floors - 1));
		next_calls.hall_down = ((calls.hall_down & ~clr_down) | btn.hall_down)
			& ~floor_mask_t'(1);
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			calls <= '0;
		end else begin
			calls <= next_calls;
		end
	end

	// the controller only opens with a serve strobe when the planner saw a call at this floor
	a_serve_has_call: assert property (
		@(posedge clk) disable iff (!reset)
		serve.valid |-> (calls.car[serve.floor] || calls.hall_up[serve.floor]
			|| calls.hall_down[serve.floor])
	) else $error("serve strobe at floor %0d with no latched call", serve.floor);

endmodule

`default_nettype wire

// File: src/elevator_pkg.sv
// shared types and timing for an 8-floor single car; timing constants are in clock cycles
`default_nettype none

package elevator_pkg;

	localparam int unsigned num_floors = 8;

	localparam int unsigned segment_cycles = 6;	// engine-on cycles per floor
	localparam int unsigned dwell_cycles = 8;	// door held open, idle command
	localparam int unsigned door_move_cycles = 2;	// each of open and close

	typedef logic [2:0] floor_t;
	typedef logic [num_floors-1:0] floor_mask_t;	// one bit per floor

	// encodings match the car interface, 0 means no drive
	typedef enum logic [1:0] {
		eng_idle = 2'd0,
		eng_down = 2'd1,
		eng_up = 2'd2
	} engine_e;

	typedef enum logic [1:0] {
		door_idle = 2'd0,
		door_open = 2'd1,
		door_close = 2'd2
	} door_e;

	typedef struct packed {
		floor_mask_t car;	// buttons inside the car
		floor_mask_t hall_up;
		floor_mask_t hall_down;
	} calls_t;

	typedef struct packed {
		logic stop_here;	// open the door at the current floor
		logic go_up;	// direction of the next segment
		logic any_call;
		logic serve_up;	// hall direction a stop clears
	} plan_t;

	typedef struct packed {
		logic valid;	// one-cycle strobe
		floor_t floor;
		logic up;	// 1 clears hall_up, 0 clears hall_down
	} serve_t;

endpackage

`default_nettype wire
